/* lg_sub.f */
+incdir+rtl
rtl/lg_pkg.sv
rtl/lg_regs.sv
rtl/lg_burst.sv
rtl/lg_table.sv
rtl/lg_pins.sv
rtl/lg_top.sv
testbench/lg_tb.sv

/* rtl/lg_burst.sv */
/*
 * logic generator burst sequencer
 * walks the table in bursts and issues one read per data cycle
 */

`default_nettype none

`include "lg_settings.svh"

module lg_burst import lg_pkg::*; (
  input  logic       bus,
  input  logic       reset,
  input  ctl_t       ctl,
  input  burst_cfg_t cfg,
  output tbl_req_t   req,
  output burst_sts_t sts
);

  gen_state_e        state;
  logic              act;  // inside data part of period
  logic [`LG_RW-1:0] rpt;  // repeat count for current word
  logic [`LG_AW-1:0] adr;  // table index
  logic [`LG_LW-1:0] cyc;  // cycle in period
  logic [`LG_NW-1:0] num;  // period number
  logic              run;
  logic              rpt_end;
  logic              dat_end;
  logic              per_end;
  logic              run_end;

  assign run     = (state == RUN);
  assign rpt_end = (rpt == cfg.bdr);
  assign dat_end = act & rpt_end & (adr == cfg.bdl);  // last data cycle of period
  assign per_end = run & (cyc == cfg.bpl);
  assign run_end = (num == cfg.bpn) & ~cfg.inf;       // final period

  //////////////////////////////////////////////////////////////////////
  // FSM and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      state <= IDLE;
      act   <= 1'b0;
      rpt   <= '0;
      adr   <= '0;
      cyc   <= '0;
      num   <= '0;
    end else if (ctl.rst || ctl.stp) begin
      state <= IDLE;  // abort from anywhere
      act   <= 1'b0;
      if (ctl.rst) begin
        rpt <= '0;
        adr <= '0;
        cyc <= '0;
        num <= '0;
      end
    end else begin
      case (state)
        IDLE: if (ctl.str) state <= ARMED;
        ARMED: begin
          if (ctl.trg) begin  // launch, first read next cycle
            state <= RUN;
            act   <= 1'b1;
            rpt   <= '0;
            adr   <= '0;
            cyc   <= '0;
            num   <= '0;
          end
        end
        RUN: begin
          // data part, each word held bdr+1 cycles
          if (act) begin
            if (rpt_end) begin
              rpt <= '0;
              if (adr == cfg.bdl) act <= 1'b0;
              else                adr <= adr + 1'b1;
            end else begin
              rpt <= rpt + 1'b1;
            end
          end
          // period boundary overrides the data update
          if (per_end) begin
            if (run_end) begin
              state <= IDLE;  // counters kept for status
              act   <= 1'b0;
            end else begin
              cyc <= '0;
              num <= num + 1'b1;
              act <= 1'b1;
              rpt <= '0;
              adr <= '0;
            end
          end else begin
            cyc <= cyc + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // table read request, no back-pressure
  assign req = '{vld: run & act, adr: adr, lst: run & dat_end & run_end};

  assign sts = '{state: state, bpl: cyc, bpn: num,
                 per: run & (cyc == '0), lst: per_end & run_end};

endmodule

`default_nettype wire

/* rtl/lg_pins.sv */
/*
 * logic generator pin stage
 * mask, polarity and per level output enable, held between samples
 */

`default_nettype none

`include "lg_settings.svh"

module lg_pins import lg_pkg::*; (
  input  logic     bus,
  input  logic     reset,
  input  smp_t     smp,
  input  pin_cfg_t cfg,
  output pin_t     pins
);

  logic [`LG_DW-1:0] o_n;
  logic [`LG_DW-1:0] e_n;

  // masked bits take the polarity value
  assign o_n = cfg.val ^ (~cfg.msk & smp.dat);
  // enable picked by output level
  assign e_n = (cfg.oe0 & ~o_n) | (cfg.oe1 & o_n);

  always_ff @(posedge bus) begin
    if (reset)        pins <= '0;
    else if (smp.vld) pins <= '{o: o_n, e: e_n};  // hold otherwise
  end

endmodule

`default_nettype wire

/* rtl/lg_pkg.sv */
/*
 * logic generator types
 * states, register offsets and the structs passed between blocks
 */

`default_nettype none

`include "lg_settings.svh"

package lg_pkg;

  typedef enum logic [1:0] {IDLE, ARMED, RUN} gen_state_e;

  // register map, byte offsets
  typedef enum logic [`LG_BAW-1:0] {
    CTL     = 'h00,  // strobes, state readback
    TRG     = 'h08,  // external trigger mask
    MODE    = 'h10,
    BDR     = 'h20,  // data repeat
    BDL     = 'h24,  // data length
    BPL     = 'h28,  // period length
    BPN     = 'h2c,  // period number
    STS_BPL = 'h30,
    STS_BPN = 'h34,
    OE0     = 'h40,
    OE1     = 'h44,
    MSK     = 'h48,
    VAL     = 'h4c
  } reg_addr_e;

  typedef struct packed {
    logic        wen;
    logic        ren;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

  typedef struct packed {logic rst; logic str; logic stp; logic trg;} ctl_t;

  typedef struct packed {
    logic              inf;  // run forever
    logic [`LG_RW-1:0] bdr;
    logic [`LG_AW-1:0] bdl;
    logic [`LG_LW-1:0] bpl;
    logic [`LG_NW-1:0] bpn;
  } burst_cfg_t;

  typedef struct packed {
    logic [`LG_DW-1:0] oe0;
    logic [`LG_DW-1:0] oe1;
    logic [`LG_DW-1:0] msk;
    logic [`LG_DW-1:0] val;
  } pin_cfg_t;

  typedef struct packed {
    gen_state_e        state;
    logic [`LG_LW-1:0] bpl;  // cycle within period
    logic [`LG_NW-1:0] bpn;  // period index
    logic              per;
    logic              lst;
  } burst_sts_t;

  typedef struct packed {logic vld; logic [`LG_AW-1:0] adr; logic lst;} tbl_req_t;
  typedef struct packed {logic vld; logic [`LG_DW-1:0] dat; logic lst;} smp_t;
  typedef struct packed {logic [`LG_DW-1:0] o; logic [`LG_DW-1:0] e;} pin_t;

endpackage

`default_nettype wire

/* rtl/lg_regs.sv */
/*
 * logic generator register block
 * config registers, control strobes, trigger masking, status and irq
 */

`default_nettype none

`include "lg_settings.svh"

module lg_regs import lg_pkg::*; (
  input  logic              bus,
  input  logic              reset,
  input  bus_req_t          reg_req,
  output bus_rsp_t          reg_rsp,
  input  logic [`LG_TN-1:0] trg,
  input  burst_sts_t        sts,
  output ctl_t              ctl,
  output burst_cfg_t        burst_cfg,
  output pin_cfg_t          pin_cfg,
  output logic              irq
);

  reg_addr_e         adr;      // decoded offset
  logic              ack;
  logic [31:0]       rdata;
  logic [`LG_TN-1:0] cfg_trg;  // trigger mask
  logic [`LG_TN-1:0] trg_r;    // external triggers, one stage
  ctl_t              stb;      // trg field carries swt here

  assign adr = reg_addr_e'(reg_req.addr[`LG_BAW-1:0]);

  //////////////////////////////////////////////////////////////////////
  // bus handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) ack <= 1'b0;
    else       ack <= reg_req.wen | reg_req.ren;  // ack next cycle
  end

  assign reg_rsp = '{ack: ack, rdata: rdata};

  // config writes
  always_ff @(posedge bus) begin
    if (reset) begin
      cfg_trg   <= '0;
      burst_cfg <= '0;
      pin_cfg   <= '0;
    end else if (reg_req.wen) begin
      case (adr)
        TRG:  cfg_trg       <= reg_req.wdata[`LG_TN-1:0];
        MODE: burst_cfg.inf <= reg_req.wdata[1];  // bit0 reserved
        BDR:  burst_cfg.bdr <= reg_req.wdata[`LG_RW-1:0];
        BDL:  burst_cfg.bdl <= reg_req.wdata[`LG_AW-1:0];
        BPL:  burst_cfg.bpl <= reg_req.wdata[`LG_LW-1:0];
        BPN:  burst_cfg.bpn <= reg_req.wdata[`LG_NW-1:0];
        OE0:  pin_cfg.oe0   <= reg_req.wdata[`LG_DW-1:0];
        OE1:  pin_cfg.oe1   <= reg_req.wdata[`LG_DW-1:0];
        MSK:  pin_cfg.msk   <= reg_req.wdata[`LG_DW-1:0];
        VAL:  pin_cfg.val   <= reg_req.wdata[`LG_DW-1:0];
        default: ;  // read only or unmapped
      endcase
    end
  end

  // readback, registered to line up with ack
  always_ff @(posedge bus) begin
    case (adr)
      CTL:     rdata <= 32'(sts.state);
      TRG:     rdata <= 32'(cfg_trg);
      MODE:    rdata <= {30'd0, burst_cfg.inf, 1'b0};
      BDR:     rdata <= 32'(burst_cfg.bdr);
      BDL:     rdata <= 32'(burst_cfg.bdl);
      BPL:     rdata <= burst_cfg.bpl;
      BPN:     rdata <= 32'(burst_cfg.bpn);
      STS_BPL: rdata <= sts.bpl;
      STS_BPN: rdata <= 32'(sts.bpn);
      OE0:     rdata <= 32'(pin_cfg.oe0);
      OE1:     rdata <= 32'(pin_cfg.oe1);
      MSK:     rdata <= 32'(pin_cfg.msk);
      VAL:     rdata <= 32'(pin_cfg.val);
      default: rdata <= '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // control strobes
  //////////////////////////////////////////////////////////////////////

  // CTL write bits become single cycle pulses
  always_ff @(posedge bus) begin
    if (reset) begin
      stb   <= '0;
      trg_r <= '0;
    end else begin
      trg_r <= trg;
      if (reg_req.wen && adr == CTL)
        stb <= '{rst: reg_req.wdata[0], str: reg_req.wdata[1],
                 stp: reg_req.wdata[2], trg: reg_req.wdata[3]};
      else
        stb <= '0;
    end
  end

  // software trigger or any unmasked external one
  assign ctl = '{rst: stb.rst, str: stb.str, stp: stb.stp,
                 trg: stb.trg | (|(trg_r & cfg_trg))};

  // interrupt, lst delayed by one
  always_ff @(posedge bus) begin
    if (reset) irq <= 1'b0;
    else       irq <= sts.lst;
  end

endmodule

`default_nettype wire

/* rtl/lg_settings.svh */
/*
 * logic generator widths
 * pin, table, counter and bus decode sizes used across the design
 */

`ifndef LG_SETTINGS_SVH
`define LG_SETTINGS_SVH

// data path
`define LG_DW 8    // pin and sample width
`define LG_AW 10   // table address bits, 1024 words

// burst counters
`define LG_RW 14   // data repeat
`define LG_LW 32   // period length
`define LG_NW 16   // period number

// misc
`define LG_TN 2    // external trigger inputs
`define LG_BAW 7   // register offset bits decoded

`endif

/* rtl/lg_table.sv */
/*
 * logic generator waveform table
 * CPU read/write port plus registered generator read port
 */

`default_nettype none

`include "lg_settings.svh"

module lg_table import lg_pkg::*; (
  input  logic     bus,
  input  logic     reset,
  input  bus_req_t tbl_req,
  output bus_rsp_t tbl_rsp,
  input  tbl_req_t req,
  output smp_t     smp
);

  logic [`LG_DW-1:0] mem [2**`LG_AW];
  logic [`LG_AW-1:0] cpu_adr;  // word index
  logic              ack;
  logic [31:0]       rdata;
  logic              vld;
  logic              lst;
  logic [`LG_DW-1:0] dat;

  assign cpu_adr = tbl_req.addr[`LG_AW+1:2];  // byte address / 4

  //////////////////////////////////////////////////////////////////////
  // CPU port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) ack <= 1'b0;
    else       ack <= tbl_req.wen | tbl_req.ren;
  end

  always_ff @(posedge bus) begin
    if (tbl_req.wen) mem[cpu_adr] <= tbl_req.wdata[`LG_DW-1:0];
    rdata <= 32'(mem[cpu_adr]);
  end

  assign tbl_rsp = '{ack: ack, rdata: rdata};

  // generator port, one cycle latency
  always_ff @(posedge bus) begin
    if (reset) begin
      vld <= 1'b0;
      lst <= 1'b0;
    end else begin
      vld <= req.vld;
      lst <= req.lst;  // last sample of last period
    end
  end

  always_ff @(posedge bus) dat <= mem[req.adr];

  assign smp = '{vld: vld, dat: dat, lst: lst};

endmodule

`default_nettype wire

/* rtl/lg_top.sv */
/*
 * logic generator top
 * registers, sequencer, waveform table and pin stage
 */

`default_nettype none

`include "lg_settings.svh"

module lg_top import lg_pkg::*; (
  input  logic              bus,
  input  logic              reset,
  input  bus_req_t          reg_req,
  output bus_rsp_t          reg_rsp,
  input  bus_req_t          tbl_req,
  output bus_rsp_t          tbl_rsp,
  input  logic [`LG_TN-1:0] trg,
  output pin_t              pins,
  output logic              irq
);

  ctl_t       ctl;
  burst_cfg_t burst_cfg;
  pin_cfg_t   pin_cfg;
  burst_sts_t sts;
  tbl_req_t   req;  // sequencer to table
  smp_t       smp;  // table to pins

  lg_regs regs_i (
    .bus(bus), .reset(reset),
    .reg_req(reg_req), .reg_rsp(reg_rsp),
    .trg(trg), .sts(sts),
    .ctl(ctl), .burst_cfg(burst_cfg), .pin_cfg(pin_cfg),
    .irq(irq)
  );

  lg_burst burst_i (
    .bus(bus), .reset(reset),
    .ctl(ctl), .cfg(burst_cfg),
    .req(req), .sts(sts)
  );

  lg_table table_i (
    .bus(bus), .reset(reset),
    .tbl_req(tbl_req), .tbl_rsp(tbl_rsp),
    .req(req), .smp(smp)
  );

  lg_pins pins_i (
    .bus(bus), .reset(reset),
    .smp(smp), .cfg(pin_cfg),
    .pins(pins)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --assert -Wno-fatal --top-module lg_tb -f lg_sub.f -o lg_sim \
  && ./obj_dir/lg_sim | tee /dev/stderr | grep -q "All tests passed!" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* testbench/lg_tb.sv */
/*
 * logic generator testbench
 * random config and table data, pins and irq checked every cycle
 * against a cycle model of the burst, mask and latency rules
 */

`default_nettype none

`include "lg_settings.svh"

module lg_tb import lg_pkg::*; ();

  localparam int rst_cycles  = 10;
  localparam int max_run     = 3 * (8 * 3 + 5 + 1);  // bpn 2, bdl 7, bdr 2, slack 5
  localparam int bus_cycles  = 2 * 12 + 2 * 16 + 20; // readback, table, setup
  localparam int cycle_limit = rst_cycles + bus_cycles + 2 * (max_run + 8) + 10 + 100;

  logic              bus = 1'b0;
  logic              reset;
  bus_req_t          reg_req;
  bus_rsp_t          reg_rsp;
  bus_req_t          tbl_req;
  bus_rsp_t          tbl_rsp;
  logic [`LG_TN-1:0] trg;
  pin_t              pins;
  logic              irq;

  integer seed   = 32'hc5c0b8f5;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;

  // model state
  logic [`LG_DW-1:0] tbl_mdl [2**`LG_AW];
  pin_t              mdl_pins = '0;  // pins as the model sees them
  int                bdl;
  int                bdr;
  int                bpl;
  int                bpn;
  logic [`LG_DW-1:0] msk;
  logic [`LG_DW-1:0] val;
  logic [`LG_DW-1:0] oe0;
  logic [`LG_DW-1:0] oe1;

  // config registers and their implemented bits
  reg_addr_e   cfg_regs [10] = '{TRG, MODE, BDR, BDL, BPL, BPN, OE0, OE1, MSK, VAL};
  logic [31:0] cfg_mask [10] = '{32'h3, 32'h2, 32'h3fff, 32'h3ff, 32'hffff_ffff,
                                 32'hffff, 32'hff, 32'hff, 32'hff, 32'hff};

  lg_top dut_i (
    .bus(bus), .reset(reset),
    .reg_req(reg_req), .reg_rsp(reg_rsp),
    .tbl_req(tbl_req), .tbl_rsp(tbl_rsp),
    .trg(trg), .pins(pins), .irq(irq)
  );

  initial begin
    forever #2 bus = ~bus;
  end

  // run limit
  always @(posedge bus) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("run stopped after %0d cycles without finishing, checks %0d, errors %0d",
               cycles, checks, errors);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] want, input logic [31:0] got);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, want, got);
    end
  endtask

  // one access per call, from one falling edge to the next
  task automatic bus_access(input bit to_tbl, input bit wr, input logic [31:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    bus_req_t rq;
    bus_rsp_t rs;
    rq = '{wen: wr, ren: !wr, addr: adr, wdata: wdat};
    if (to_tbl) tbl_req = rq;
    else        reg_req = rq;
    @(negedge bus);
    reg_req = '0;
    tbl_req = '0;
    rs = to_tbl ? tbl_rsp : reg_rsp;  // ack due in this cycle
    compare(to_tbl ? "table ack" : "register ack", 32'd1, 32'(rs.ack));
    rdat = rs.rdata;
  endtask

  task automatic write_reg(input reg_addr_e a, input logic [31:0] d);
    logic [31:0] dummy;
    bus_access(1'b0, 1'b1, 32'(a), d, dummy);
  endtask

  task automatic read_reg(input reg_addr_e a, output logic [31:0] d);
    bus_access(1'b0, 1'b0, 32'(a), '0, d);
  endtask

  task automatic write_word(input int a, input logic [`LG_DW-1:0] d);
    logic [31:0] dummy;
    bus_access(1'b1, 1'b1, 32'(a << 2), 32'(d), dummy);  // byte address
  endtask

  task automatic read_word(input int a, output logic [31:0] d);
    bus_access(1'b1, 1'b0, 32'(a << 2), '0, d);
  endtask

  task automatic pulse_trigger(input logic [`LG_TN-1:0] t);
    trg = t;
    @(negedge bus);
    trg = '0;
  endtask

  // masked bits take the polarity value and the enable follows the level
  function automatic pin_t pin_level(input logic [`LG_DW-1:0] d);
    pin_t p;
    for (int i = 0; i < `LG_DW; i++) begin
      p.o[i] = msk[i] ? val[i] : d[i] ^ val[i];  // polarity inverts data bits too
      p.e[i] = p.o[i] ? oe1[i] : oe0[i];
    end
    return p;
  endfunction

  task automatic configure_burst();
    bdl = int'({$random(seed)} % 32'd8);
    bdr = int'({$random(seed)} % 32'd3);
    bpn = int'({$random(seed)} % 32'd3);
    bpl = (bdl + 1) * (bdr + 1) + int'({$random(seed)} % 32'd6);  // room for data
    msk = 8'($random(seed));
    val = 8'($random(seed));
    oe0 = 8'($random(seed));
    oe1 = 8'($random(seed));
    write_reg(MODE, 32'd0);  // finite run
    write_reg(TRG, 32'd0);
    write_reg(BDL, 32'(bdl));
    write_reg(BDR, 32'(bdr));
    write_reg(BPL, 32'(bpl));
    write_reg(BPN, 32'(bpn));
    write_reg(MSK, 32'(msk));
    write_reg(VAL, 32'(val));
    write_reg(OE0, 32'(oe0));
    write_reg(OE1, 32'(oe1));
  endtask

  // entered on the falling edge before the launch edge and checks n cycles
  // stop_j below 0 means no stop strobe
  task automatic follow_burst(input string name, input int n, input bit launch,
                              input int stop_j);
    int per_len;
    int run_len;
    int m;
    int k;
    int c;
    per_len = bpl + 1;
    run_len = (bpn + 1) * per_len;
    for (int j = 0; j < n; j++) begin
      m = j - 1;            // run cycle now in progress
      k = m - 2;            // request now reaching the pins
      c = k % per_len;      // cycle in period
      if (launch && k >= 0 && k < run_len && (stop_j < 0 || k <= stop_j)
          && c < (bdl + 1) * (bdr + 1))
        mdl_pins = pin_level(tbl_mdl[c / (bdr + 1)]);
      compare($sformatf("%s o", name), 32'(mdl_pins.o), 32'(pins.o));
      compare($sformatf("%s e", name), 32'(mdl_pins.e), 32'(pins.e));
      compare($sformatf("%s irq", name), 32'(launch && stop_j < 0 && m == run_len),
              32'(irq));  // one cycle after lst of the final cycle
      if (j == stop_j)
        reg_req = '{wen: 1'b1, ren: 1'b0, addr: 32'(CTL), wdata: 32'h4};  // stop
      if (stop_j >= 0 && j == stop_j + 1) begin
        reg_req = '0;
        compare("stop ack", 32'd1, 32'(reg_rsp.ack));
      end
      @(negedge bus);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]       rd;
    logic [31:0]       wv [10];
    int                adr_list [16];
    int                run_len;
    int                stop_j;
    logic [`LG_TN-1:0] tmask;

    reset   = 1'b1;
    reg_req = '0;
    tbl_req = '0;
    trg     = '0;
    repeat (rst_cycles) @(negedge bus);
    reset = 1'b0;

    // register readback masked to width
    for (int i = 0; i < 10; i++) begin
      wv[i] = $random(seed);
      write_reg(cfg_regs[i], wv[i]);
    end
    for (int i = 0; i < 10; i++) begin
      read_reg(cfg_regs[i], rd);
      compare($sformatf("readback %s", cfg_regs[i].name()), wv[i] & cfg_mask[i], rd);
    end
    bus_access(1'b0, 1'b0, 32'h50, '0, rd);  // unmapped offset
    compare("unmapped read", 32'd0, rd);

    // table readback with the burst words first
    for (int i = 0; i < 16; i++) begin
      adr_list[i] = (i < 8) ? i : int'({$random(seed)} % 32'd1024);
      tbl_mdl[adr_list[i]] = 8'($random(seed));
      write_word(adr_list[i], tbl_mdl[adr_list[i]]);
    end
    for (int i = 0; i < 16; i++) begin
      read_word(adr_list[i], rd);
      compare($sformatf("table word %0d", adr_list[i]), 32'(tbl_mdl[adr_list[i]]), rd);
    end

    // software triggered burst and completion
    configure_burst();
    run_len = (bpn + 1) * (bpl + 1);
    write_reg(CTL, 32'h2);  // str
    write_reg(CTL, 32'h8);  // swt
    follow_burst("burst", run_len + 6, 1'b1, -1);
    read_reg(STS_BPN, rd);
    compare("periods done", 32'(bpn), rd);
    read_reg(CTL, rd);
    compare("state after burst", 32'(IDLE), rd);
    compare("final o", 32'(mdl_pins.o), 32'(pins.o));
    compare("final e", 32'(mdl_pins.e), 32'(pins.e));

    // external trigger with mask cleared does nothing
    write_reg(CTL, 32'h2);
    pulse_trigger(2'b11);
    follow_burst("masked trigger", 10, 1'b0, -1);
    read_reg(CTL, rd);
    compare("still armed", 32'(ARMED), rd);

    // unmasked trigger launches and is stopped before the final cycle
    tmask = ($random(seed) & 1) ? 2'b01 : 2'b10;
    write_reg(TRG, 32'(tmask));
    stop_j = int'({$random(seed)} % 32'(run_len - 1));
    pulse_trigger(tmask);
    follow_burst("stopped burst", run_len + 6, 1'b1, stop_j);
    read_reg(CTL, rd);
    compare("state after stop", 32'(IDLE), rd);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
